/* cpuCtrlPkg.sv */
////////////////////////////////////////
// CPU control unit types
////////////////////////////////////////
`default_nettype none

package cpuCtrlPkg;

    typedef logic [31:0] irWord_t;

    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;

    typedef enum logic [4:0] {
        opLd   = 5'd0,  opLdi  = 5'd1,  opSt   = 5'd2,  opAdd  = 5'd3,
        opSub  = 5'd4,  opAnd  = 5'd5,  opOr   = 5'd6,  opShr  = 5'd7,
        opShra = 5'd8,  opShl  = 5'd9,  opRor  = 5'd10, opRol  = 5'd11,
        opAddi = 5'd12, opAndi = 5'd13, opOri  = 5'd14, opMul  = 5'd15,
        opDiv  = 5'd16, opNeg  = 5'd17, opNot  = 5'd18, opBr   = 5'd19,
        opJr   = 5'd20, opJal  = 5'd21, opIn   = 5'd22, opOut  = 5'd23,
        opMfhi = 5'd24, opMflo = 5'd25
    } irOpcode_t;

    typedef enum logic [4:0] {
        aluNop  = 5'd0,  aluAdd = 5'd1,  aluSub = 5'd2,  aluMul = 5'd3,
        aluDiv  = 5'd4,  aluShr = 5'd5,  aluShl = 5'd6,  aluShra = 5'd7,
        aluRor  = 5'd8,  aluRol = 5'd9,  aluAnd = 5'd10, aluOr  = 5'd11,
        aluNeg  = 5'd12, aluNot = 5'd15
    } aluOp_t;

    typedef enum logic [3:0] {
        clsRegAlu, clsMulDiv, clsUnary, clsImmAlu, clsLoad, clsLoadImm,
        clsStore, clsBranch, clsJumpReg, clsJumpLink, clsMoveHi, clsMoveLo,
        clsPortIn, clsPortOut, clsNop
    } instrClass_t;

    // Steps 0..2 fetch, 3..7 execute
    typedef logic [2:0] stepIdx_t;

    typedef struct packed {
        logic read;      logic write;     logic baOut;     logic rIn;
        logic rOut;      logic gra;       logic grb;       logic grc;
        logic connIn;    logic marIn;     logic mdrIn;     logic hiIn;
        logic loIn;      logic yIn;       logic zIn;       logic pcIn;
        logic irIn;      logic incPc;     logic outPortIn; logic hiOut;
        logic loOut;     logic zLowOut;   logic zHighOut;  logic mdrOut;
        logic cOut;      logic inPortOut; logic pcOut;
        aluOp_t aluOp;
    } ctrlWord_t;

    function automatic stepIdx_t lastStep(instrClass_t cls);
        case (cls)
            clsRegAlu, clsUnary, clsImmAlu, clsLoadImm: return 3'd5;
            clsMulDiv, clsBranch:                       return 3'd6;
            clsLoad, clsStore:                          return 3'd7;
            default:                                    return 3'd3;
        endcase
    endfunction

    function automatic instrClass_t classOf(irOpcode_t op);
        case (op)
            opAdd, opSub, opAnd, opOr, opShl, opShr, opShra, opRor, opRol:
                return clsRegAlu;
            opMul, opDiv:           return clsMulDiv;
            opNeg, opNot:           return clsUnary;
            opAddi, opAndi, opOri:  return clsImmAlu;
            opLd:                   return clsLoad;
            opLdi:                  return clsLoadImm;
            opSt:                   return clsStore;
            opBr:                   return clsBranch;
            opJr:                   return clsJumpReg;
            opJal:                  return clsJumpLink;
            opMfhi:                 return clsMoveHi;
            opMflo:                 return clsMoveLo;
            opIn:                   return clsPortIn;
            opOut:                  return clsPortOut;
            // Codes 26..31 run as a one-step nop
            default:                return clsNop;
        endcase
    endfunction

    function automatic aluOp_t aluOpOf(irOpcode_t op);
        case (op)
            opAdd, opAddi:  return aluAdd;
            opSub:          return aluSub;
            opAnd, opAndi:  return aluAnd;
            opOr, opOri:    return aluOr;
            opShr:          return aluShr;
            opShra:         return aluShra;
            opShl:          return aluShl;
            opRor:          return aluRor;
            opRol:          return aluRol;
            opMul:          return aluMul;
            opDiv:          return aluDiv;
            opNeg:          return aluNeg;
            opNot:          return aluNot;
            default:        return aluNop;
        endcase
    endfunction

endpackage

`default_nettype wire

/* ctrlStepIf.sv */
////////////////////////////////////////
// Sequencer state bus
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface ctrlStepIf;
    import cpuCtrlPkg::*;

    stepIdx_t    step;
    irOpcode_t   opcode;
    instrClass_t instrClass;
    logic        initStep;
    logic        halted;

    modport seq (
        output step, opcode, instrClass, initStep, halted
    );

    modport dec (
        input step, opcode, instrClass, initStep, halted
    );

endinterface

`default_nettype wire

/* instrSequencer.sv */
////////////////////////////////////////
// Instruction step sequencer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instrSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               stop,
    input  cpuCtrlPkg::irWord_t irData,
    ctrlStepIf.seq             stepBus
);
    import cpuCtrlPkg::*;

    stepIdx_t    stepReg;
    stepIdx_t    savedStep;
    stepIdx_t    nextStep;
    stepIdx_t    advStep;
    irOpcode_t   opcodeReg;
    irOpcode_t   irOpcode;
    instrClass_t classReg;
    logic        initReg;
    logic        haltedReg;
    logic        fetchEnd;

    assign irOpcode = irOpcode_t'(irData[opcodeMsb:opcodeLsb]);

    // Edge ending fetch step 2 latches even when stop is high
    assign fetchEnd = !haltedReg && !initReg && (stepReg == 3'd2);

    // lastStep is never below 3, so fetch steps always just count up
    always_comb begin
        if (stepReg == lastStep(classReg)) begin
            advStep = 3'd0;
        end else begin
            advStep = stepReg + 3'd1;
        end
    end

    // Step the unit would enter at this edge without a stop
    always_comb begin
        if (haltedReg) begin
            nextStep = savedStep;
        end else if (initReg) begin
            nextStep = 3'd0;
        end else begin
            nextStep = advStep;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stepReg   <= 3'd0;
            savedStep <= 3'd0;
            initReg   <= 1'b1;
            haltedReg <= 1'b0;
        end else begin
            initReg <= 1'b0;
            if (stop) begin
                haltedReg <= 1'b1;
                savedStep <= nextStep;
            end else begin
                haltedReg <= 1'b0;
                stepReg   <= nextStep;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            classReg <= clsNop;
        end else if (fetchEnd) begin
            classReg <= classOf(irOpcode);
        end
    end

    // Opcode latched at the end of fetch
    always_ff @(posedge clk) begin
        if (fetchEnd) begin
            opcodeReg <= irOpcode;
        end
    end

    assign stepBus.step       = stepReg;
    assign stepBus.opcode     = opcodeReg;
    assign stepBus.instrClass = classReg;
    assign stepBus.initStep   = initReg;
    assign stepBus.halted     = haltedReg;

endmodule

`default_nettype wire

/* ctrlWordDecoder.sv */
////////////////////////////////////////
// Control word decoder
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrlWordDecoder (
    ctrlStepIf.dec                stepBus,
    output cpuCtrlPkg::ctrlWord_t ctrl,
    output logic                  run,
    output logic                  clr
);
    import cpuCtrlPkg::*;

    aluOp_t opAlu;

    assign opAlu = aluOpOf(stepBus.opcode);
    assign run   = !stepBus.halted;
    assign clr   = stepBus.initStep;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluNop;
        if (!stepBus.halted && !stepBus.initStep) begin
            case (stepBus.step)
                3'd0: begin
                    ctrl.pcOut = 1'b1;
                    ctrl.marIn = 1'b1;
                    ctrl.zIn   = 1'b1;
                    ctrl.incPc = 1'b1;
                end
                3'd1: begin
                    ctrl.zLowOut = 1'b1;
                    ctrl.pcIn    = 1'b1;
                    ctrl.read    = 1'b1;
                    ctrl.mdrIn   = 1'b1;
                end
                3'd2: begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.irIn   = 1'b1;
                end
                default: begin
                    case (stepBus.instrClass)
                        clsRegAlu, clsUnary, clsImmAlu, clsMulDiv: begin
                            case (stepBus.step)
                                3'd3: begin
                                    ctrl.grb = 1'b1;
                                    ctrl.yIn = 1'b1;
                                end
                                3'd4: begin
                                    ctrl.zIn   = 1'b1;
                                    ctrl.aluOp = opAlu;
                                    ctrl.cOut  = (stepBus.instrClass == clsImmAlu);
                                    // Second operand from register c
                                    ctrl.grc   = (stepBus.instrClass == clsRegAlu) ||
                                                 (stepBus.instrClass == clsMulDiv);
                                    ctrl.rOut  = ctrl.grc;
                                end
                                3'd5: begin
                                    ctrl.zLowOut = 1'b1;
                                    ctrl.loIn    = (stepBus.instrClass == clsMulDiv);
                                    ctrl.gra     = !ctrl.loIn;
                                    ctrl.rIn     = !ctrl.loIn;
                                end
                                3'd6: begin
                                    ctrl.zHighOut = 1'b1;
                                    ctrl.hiIn     = 1'b1;
                                end
                                default: ;
                            endcase
                        end
                        clsLoad, clsLoadImm, clsStore: begin
                            case (stepBus.step)
                                3'd3: begin
                                    ctrl.grb   = 1'b1;
                                    ctrl.baOut = 1'b1;
                                    ctrl.yIn   = 1'b1;
                                end
                                3'd4: begin
                                    ctrl.zIn   = 1'b1;
                                    ctrl.cOut  = 1'b1;
                                    ctrl.aluOp = aluAdd;
                                end
                                3'd5: begin
                                    ctrl.zLowOut = 1'b1;
                                    ctrl.marIn   = (stepBus.instrClass != clsLoadImm);
                                    ctrl.gra     = (stepBus.instrClass == clsLoadImm);
                                    ctrl.rIn     = (stepBus.instrClass == clsLoadImm);
                                end
                                3'd6: begin
                                    ctrl.mdrIn = 1'b1;
                                    ctrl.read  = (stepBus.instrClass == clsLoad);
                                    ctrl.write = (stepBus.instrClass == clsStore);
                                    ctrl.rOut  = ctrl.write;
                                    ctrl.gra   = ctrl.write;
                                end
                                3'd7: begin
                                    // Store idles here for write recovery
                                    ctrl.mdrOut = (stepBus.instrClass == clsLoad);
                                    ctrl.gra    = ctrl.mdrOut;
                                    ctrl.rIn    = ctrl.mdrOut;
                                end
                                default: ;
                            endcase
                        end
                        clsBranch: begin
                            case (stepBus.step)
                                3'd3: begin
                                    ctrl.gra    = 1'b1;
                                    ctrl.rOut   = 1'b1;
                                    ctrl.connIn = 1'b1;
                                end
                                3'd4: begin
                                    ctrl.pcOut = 1'b1;
                                    ctrl.yIn   = 1'b1;
                                end
                                3'd5: begin
                                    ctrl.cOut  = 1'b1;
                                    ctrl.zIn   = 1'b1;
                                    ctrl.aluOp = aluAdd;
                                end
                                3'd6: begin
                                    ctrl.zLowOut = 1'b1;
                                    ctrl.pcIn    = 1'b1;
                                end
                                default: ;
                            endcase
                        end
                        default: begin
                            // Single-step classes all run in step 3
                            ctrl.gra       = (stepBus.instrClass != clsNop);
                            ctrl.pcIn      = (stepBus.instrClass == clsJumpReg);
                            ctrl.pcOut     = (stepBus.instrClass == clsJumpLink);
                            ctrl.hiOut     = (stepBus.instrClass == clsMoveHi);
                            ctrl.loOut     = (stepBus.instrClass == clsMoveLo);
                            ctrl.inPortOut = (stepBus.instrClass == clsPortIn);
                            ctrl.outPortIn = (stepBus.instrClass == clsPortOut);
                            ctrl.rOut      = ctrl.pcIn || ctrl.outPortIn;
                            ctrl.rIn       = ctrl.pcOut || ctrl.hiOut || ctrl.loOut ||
                                             ctrl.inPortOut;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* cpuCtrlUnit.sv */
////////////////////////////////////////
// CPU control unit top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpuCtrlUnit (
    input  logic        clk,
    input  logic        reset,
    input  logic        stop,
    input  logic [31:0] irData,
    output logic        run,
    output logic        clr,
    output logic        read,
    output logic        write,
    output logic        baOut,
    output logic        rIn,
    output logic        rOut,
    output logic        gra,
    output logic        grb,
    output logic        grc,
    output logic        connIn,
    output logic        marIn,
    output logic        mdrIn,
    output logic        hiIn,
    output logic        loIn,
    output logic        yIn,
    output logic        zIn,
    output logic        pcIn,
    output logic        irIn,
    output logic        incPc,
    output logic        outPortIn,
    output logic        hiOut,
    output logic        loOut,
    output logic        zLowOut,
    output logic        zHighOut,
    output logic        mdrOut,
    output logic        cOut,
    output logic        inPortOut,
    output logic        pcOut,
    output logic [4:0]  aluOp
);
    import cpuCtrlPkg::*;

    ctrlWord_t ctrl;

    ctrlStepIf stepBus ();

    instrSequencer uSequencer (
        .clk     (clk),
        .reset   (reset),
        .stop    (stop),
        .irData  (irData),
        .stepBus (stepBus.seq)
    );

    ctrlWordDecoder uDecoder (
        .stepBus (stepBus.dec),
        .ctrl    (ctrl),
        .run     (run),
        .clr     (clr)
    );

    // Flatten control word onto the datapath pins
    assign read      = ctrl.read;
    assign write     = ctrl.write;
    assign baOut     = ctrl.baOut;
    assign rIn       = ctrl.rIn;
    assign rOut      = ctrl.rOut;
    assign gra       = ctrl.gra;
    assign grb       = ctrl.grb;
    assign grc       = ctrl.grc;
    assign connIn    = ctrl.connIn;
    assign marIn     = ctrl.marIn;
    assign mdrIn     = ctrl.mdrIn;
    assign hiIn      = ctrl.hiIn;
    assign loIn      = ctrl.loIn;
    assign yIn       = ctrl.yIn;
    assign zIn       = ctrl.zIn;
    assign pcIn      = ctrl.pcIn;
    assign irIn      = ctrl.irIn;
    assign incPc     = ctrl.incPc;
    assign outPortIn = ctrl.outPortIn;
    assign hiOut     = ctrl.hiOut;
    assign loOut     = ctrl.loOut;
    assign zLowOut   = ctrl.zLowOut;
    assign zHighOut  = ctrl.zHighOut;
    assign mdrOut    = ctrl.mdrOut;
    assign cOut      = ctrl.cOut;
    assign inPortOut = ctrl.inPortOut;
    assign pcOut     = ctrl.pcOut;
    assign aluOp     = ctrl.aluOp;

endmodule

`default_nettype wire

/* cpuCtrlUnit_sva.sv */
////////////////////////////////////////
// Control unit assertions
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpuCtrlUnit_sva (
    input logic        clk,
    input logic        reset,
    input logic        run,
    input logic        read,
    input logic        write,
    input logic        zIn,
    input logic [4:0]  aluOp,
    input logic [26:0] strobes
);

    // Halted unit drives nothing
    idleWhenHalted: assert property (
        @(posedge clk) disable iff (reset) !run |-> (strobes == '0)
    ) else $error("strobe active while run is low");

    noReadWrite: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    ) else $error("read and write high together");

    // ALU result only lands in Z
    aluOnlyWithZ: assert property (
        @(posedge clk) disable iff (reset) (aluOp != 5'd0) |-> zIn
    ) else $error("aluOp nonzero without zIn");

endmodule

`default_nettype wire

/* tbCpuCtrl.sv */
////////////////////////////////////////
// Control unit testbench
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbCpuCtrl;
    import cpuCtrlPkg::*;

    localparam int numInstr  = 400;
    localparam int clkPeriod = 4;
    localparam int resetCycles = 3;

    logic        clk;
    logic        reset;
    logic        stop;
    logic [31:0] irData;

    wire [26:0]  strobes;
    wire [4:0]   gotAlu;
    wire         gotRun;
    wire         gotClr;
    ctrlWord_t   gotWord;

    // Model state
    stepIdx_t    mStep;
    stepIdx_t    mSaved;
    logic        mInit;
    logic        mHalted;
    instrClass_t mClass;
    logic [4:0]  mOp;

    logic [31:0] lfsrState;
    int          issued;
    int          stopCycles;
    int          cyclesRun;

    cpuCtrlUnit DUT (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .irData    (irData),
        .run       (gotRun),
        .clr       (gotClr),
        .read      (strobes[26]),
        .write     (strobes[25]),
        .baOut     (strobes[24]),
        .rIn       (strobes[23]),
        .rOut      (strobes[22]),
        .gra       (strobes[21]),
        .grb       (strobes[20]),
        .grc       (strobes[19]),
        .connIn    (strobes[18]),
        .marIn     (strobes[17]),
        .mdrIn     (strobes[16]),
        .hiIn      (strobes[15]),
        .loIn      (strobes[14]),
        .yIn       (strobes[13]),
        .zIn       (strobes[12]),
        .pcIn      (strobes[11]),
        .irIn      (strobes[10]),
        .incPc     (strobes[9]),
        .outPortIn (strobes[8]),
        .hiOut     (strobes[7]),
        .loOut     (strobes[6]),
        .zLowOut   (strobes[5]),
        .zHighOut  (strobes[4]),
        .mdrOut    (strobes[3]),
        .cOut      (strobes[2]),
        .inPortOut (strobes[1]),
        .pcOut     (strobes[0]),
        .aluOp     (gotAlu)
    );

    bind cpuCtrlUnit cpuCtrlUnit_sva uSva (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .read    (read),
        .write   (write),
        .zIn     (zIn),
        .aluOp   (aluOp),
        .strobes ({read, write, baOut, rIn, rOut, gra, grb, grc, connIn, marIn,
                   mdrIn, hiIn, loIn, yIn, zIn, pcIn, irIn, incPc, outPortIn,
                   hiOut, loOut, zLowOut, zHighOut, mdrOut, cOut, inPortOut, pcOut})
    );

    // Strobes sit above aluOp in the packed word
    assign gotWord = ctrlWord_t'({strobes, gotAlu});

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    function automatic instrClass_t classify(logic [4:0] op);
        case (op)
            5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11: return clsRegAlu;
            5'd12, 5'd13, 5'd14: return clsImmAlu;
            5'd15, 5'd16:        return clsMulDiv;
            5'd17, 5'd18:        return clsUnary;
            5'd0:                return clsLoad;
            5'd1:                return clsLoadImm;
            5'd2:                return clsStore;
            5'd19:               return clsBranch;
            5'd20:               return clsJumpReg;
            5'd21:               return clsJumpLink;
            5'd22:               return clsPortIn;
            5'd23:               return clsPortOut;
            5'd24:               return clsMoveHi;
            5'd25:               return clsMoveLo;
            default:             return clsNop;
        endcase
    endfunction

    function automatic aluOp_t aluFor(logic [4:0] op);
        case (op)
            5'd3, 5'd12:  return aluAdd;
            5'd4:         return aluSub;
            5'd5, 5'd13:  return aluAnd;
            5'd6, 5'd14:  return aluOr;
            5'd7:         return aluShr;
            5'd8:         return aluShra;
            5'd9:         return aluShl;
            5'd10:        return aluRor;
            5'd11:        return aluRol;
            5'd15:        return aluMul;
            5'd16:        return aluDiv;
            5'd17:        return aluNeg;
            5'd18:        return aluNot;
            default:      return aluNop;
        endcase
    endfunction

    function automatic stepIdx_t lastOf(instrClass_t c);
        case (c)
            clsRegAlu, clsUnary, clsImmAlu, clsLoadImm: return 3'd5;
            clsMulDiv, clsBranch:                       return 3'd6;
            clsLoad, clsStore:                          return 3'd7;
            default:                                    return 3'd3;
        endcase
    endfunction

    function automatic ctrlWord_t execWord(stepIdx_t s, instrClass_t c, logic [4:0] op);
        ctrlWord_t w;
        logic      aluFamily;
        logic      memFamily;
        w = '0;
        aluFamily = (c == clsRegAlu) || (c == clsUnary) || (c == clsImmAlu) ||
                    (c == clsMulDiv);
        memFamily = (c == clsLoad) || (c == clsLoadImm) || (c == clsStore);
        if (aluFamily && s == 3'd3) begin
            w.grb = 1'b1;
            w.yIn = 1'b1;
        end else if (aluFamily && s == 3'd4) begin
            w.zIn   = 1'b1;
            w.aluOp = aluFor(op);
            w.grc   = (c == clsRegAlu) || (c == clsMulDiv);
            w.rOut  = (c == clsRegAlu) || (c == clsMulDiv);
            w.cOut  = (c == clsImmAlu);
        end else if (c == clsMulDiv && s == 3'd5) begin
            w.zLowOut = 1'b1;
            w.loIn    = 1'b1;
        end else if (c == clsMulDiv && s == 3'd6) begin
            w.zHighOut = 1'b1;
            w.hiIn     = 1'b1;
        end else if (aluFamily && s == 3'd5) begin
            w.zLowOut = 1'b1;
            w.gra     = 1'b1;
            w.rIn     = 1'b1;
        end else if (memFamily && s == 3'd3) begin
            w.grb   = 1'b1;
            w.baOut = 1'b1;
            w.yIn   = 1'b1;
        end else if (memFamily && s == 3'd4) begin
            w.zIn   = 1'b1;
            w.cOut  = 1'b1;
            w.aluOp = aluAdd;
        end else if (c == clsLoadImm && s == 3'd5) begin
            w.zLowOut = 1'b1;
            w.gra     = 1'b1;
            w.rIn     = 1'b1;
        end else if (memFamily && s == 3'd5) begin
            w.zLowOut = 1'b1;
            w.marIn   = 1'b1;
        end else if (c == clsLoad && s == 3'd6) begin
            w.read  = 1'b1;
            w.mdrIn = 1'b1;
        end else if (c == clsLoad && s == 3'd7) begin
            w.mdrOut = 1'b1;
            w.gra    = 1'b1;
            w.rIn    = 1'b1;
        end else if (c == clsStore && s == 3'd6) begin
            w.write = 1'b1;
            w.mdrIn = 1'b1;
            w.rOut  = 1'b1;
            w.gra   = 1'b1;
        end else if (c == clsBranch) begin
            case (s)
                3'd3: begin
                    w.gra    = 1'b1;
                    w.rOut   = 1'b1;
                    w.connIn = 1'b1;
                end
                3'd4: begin
                    w.pcOut = 1'b1;
                    w.yIn   = 1'b1;
                end
                3'd5: begin
                    w.cOut  = 1'b1;
                    w.zIn   = 1'b1;
                    w.aluOp = aluAdd;
                end
                3'd6: begin
                    w.zLowOut = 1'b1;
                    w.pcIn    = 1'b1;
                end
                default: ;
            endcase
        end else if (s == 3'd3) begin
            // One-step classes; nop stays idle
            w.gra       = (c != clsNop);
            w.rOut      = (c == clsJumpReg) || (c == clsPortOut);
            w.rIn       = (c == clsJumpLink) || (c == clsMoveHi) ||
                          (c == clsMoveLo) || (c == clsPortIn);
            w.pcIn      = (c == clsJumpReg);
            w.pcOut     = (c == clsJumpLink);
            w.hiOut     = (c == clsMoveHi);
            w.loOut     = (c == clsMoveLo);
            w.inPortOut = (c == clsPortIn);
            w.outPortIn = (c == clsPortOut);
        end
        return w;
    endfunction

    function automatic ctrlWord_t expectWord(stepIdx_t s, instrClass_t c, logic [4:0] op);
        ctrlWord_t w;
        w = '0;
        case (s)
            3'd0: begin
                w.pcOut = 1'b1;
                w.marIn = 1'b1;
                w.zIn   = 1'b1;
                w.incPc = 1'b1;
            end
            3'd1: begin
                w.zLowOut = 1'b1;
                w.pcIn    = 1'b1;
                w.read    = 1'b1;
                w.mdrIn   = 1'b1;
            end
            3'd2: begin
                w.mdrOut = 1'b1;
                w.irIn   = 1'b1;
            end
            default: w = execWord(s, c, op);
        endcase
        return w;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareBit(input string name, input logic want, input logic got);
        if (got !== want) begin
            abortRun($sformatf("FAIL %s expected %h got %h", name, want, got));
        end
    endtask

    task automatic compareCtrl(input ctrlWord_t want, input ctrlWord_t got);
        if (got !== want) begin
            abortRun($sformatf("FAIL ctrlWord expected %h got %h at step %0d opcode %h",
                               want, got, mStep, mOp));
        end
    endtask

    // Sequencing as seen at one rising edge
    task automatic advanceModel();
        stepIdx_t nxt;
        if (mInit) begin
            nxt = 3'd0;
        end else if (mHalted) begin
            nxt = mSaved;
        end else if (mStep == lastOf(mClass)) begin
            nxt = 3'd0;
        end else begin
            nxt = mStep + 3'd1;
        end
        if (!mInit && !mHalted && mStep == 3'd2) begin
            mOp    = irData[31:27];
            mClass = classify(mOp);
        end
        mInit = 1'b0;
        if (stop) begin
            mHalted = 1'b1;
            mSaved  = nxt;
            stopCycles++;
        end else begin
            mHalted = 1'b0;
            mStep   = nxt;
        end
    endtask

    task automatic checkOutputs();
        ctrlWord_t want;
        if (mHalted || mInit) begin
            want = '0;
        end else begin
            want = expectWord(mStep, mClass, mOp);
        end
        compareBit("run", !mHalted, gotRun);
        compareBit("clr", mInit, gotClr);
        compareCtrl(want, gotWord);
    endtask

    task automatic driveInputs();
        logic [31:0] bits;
        takeBits(3, bits);
        stop = (bits[2:0] == 3'd0);
        // New word must be present at the edge ending step 2
        if (gotWord.irIn) begin
            takeBits(32, bits);
            irData = bits;
            issued++;
        end
    endtask

    initial begin
        cyclesRun = 0;
        forever begin
            @(posedge clk);
            cyclesRun++;
            if (cyclesRun > 8 * numInstr * 2 + stopCycles + resetCycles + 4) begin
                abortRun("Run hung: instructions did not complete within the cycle budget");
            end
        end
    end

    initial begin
        lfsrState  = 32'd68477;
        reset      = 1'b1;
        stop       = 1'b0;
        irData     = '0;
        issued     = 0;
        stopCycles = 0;
        mInit      = 1'b1;
        mHalted    = 1'b0;
        mStep      = 3'd0;
        mSaved     = 3'd0;
        mClass     = clsNop;
        mOp        = '0;
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkOutputs();
        end
        reset = 1'b0;
        while (!(issued == numInstr && mStep == 3'd0 && !mHalted)) begin
            @(posedge clk);
            advanceModel();
            #1;
            checkOutputs();
            driveInputs();
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
cpuCtrlPkg.sv
ctrlStepIf.sv
instrSequencer.sv
ctrlWordDecoder.sv
cpuCtrlUnit.sv
cpuCtrlUnit_sva.sv
tbCpuCtrl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f filelist.f \
    --top-module tbCpuCtrl \
    -o simCpuCtrl

./obj_dir/simCpuCtrl | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
